// ==== rtl/rb_pkg.sv ====
// RadioBox shared definitions: register map, bit positions, LED modes and bus/config structs
package rb_pkg;

  // ----------------------------------------------------------
  // register map, byte offsets in the low 20 address bits
  // ----------------------------------------------------------
  localparam logic [19:0] RB_ADDR_CTRL       = 20'h00000;  // control word
  localparam logic [19:0] RB_ADDR_STATUS     = 20'h00004;  // read only
  localparam logic [19:0] RB_ADDR_LED_CTRL   = 20'h0001C;  // led mode, bits 3:0
  localparam logic [19:0] RB_ADDR_OSC_INC_LO = 20'h00020;  // phase increment 31:0
  localparam logic [19:0] RB_ADDR_OSC_INC_HI = 20'h00024;  // phase increment 47:32
  localparam logic [19:0] RB_ADDR_OSC_OFS_LO = 20'h00028;  // phase offset 31:0
  localparam logic [19:0] RB_ADDR_OSC_OFS_HI = 20'h0002C;  // phase offset 47:32
  localparam logic [19:0] RB_ADDR_MIX_GAIN   = 20'h00030;  // signed gain
  localparam logic [19:0] RB_ADDR_MIX_OFS_LO = 20'h00038;  // mixer offset 31:0
  localparam logic [19:0] RB_ADDR_MIX_OFS_HI = 20'h0003C;  // mixer offset 47:32

  // control word bits
  localparam int RB_CTRL_ENABLE     = 0;  // subsystem on
  localparam int RB_CTRL_OSC_RESYNC = 4;  // phase held at zero

  // status word bits
  localparam int RB_STAT_CLK_EN     = 0;
  localparam int RB_STAT_RESET      = 1;   // subsystem out of reset
  localparam int RB_STAT_LEDS_EN    = 2;
  localparam int RB_STAT_OSC_ZERO   = 4;   // osc sample is zero
  localparam int RB_STAT_OSC_VALID  = 5;
  localparam int RB_STAT_MIX_VALID  = 6;
  localparam int RB_STAT_LED_LSB    = 24;  // 31:24 mirror the leds

  typedef enum logic [3:0] {
    DISABLED = 4'd0,  // leds left to the host
    OFF      = 4'd1,  // all dark
    MIX_MAG  = 4'd2,  // bar from mixer output
    OSC_MAG  = 4'd3   // bar from oscillator output
  } rb_led_mode_e;

  typedef logic [31:0]        rb_word_t;
  typedef logic [47:0]        rb_phase_t;   // phase, inc and offsets
  typedef logic signed [15:0] rb_sample_t;

  typedef struct packed {
    logic [31:0] address;
    rb_word_t    wdata;
    logic        wen;   // one cycle strobe
    logic        ren;   // one cycle strobe
  } rb_sys_req_t;

  typedef struct packed {
    rb_word_t rdata;
    logic     err;
    logic     ack;
  } rb_sys_rsp_t;

  typedef struct packed {
    rb_phase_t inc;
    rb_phase_t ofs;
    logic      resync;
  } rb_osc_cfg_t;

  typedef struct packed {
    logic signed [31:0] gain;
    rb_phase_t          ofs;  // unsigned
  } rb_mix_cfg_t;

  typedef struct packed {
    logic       clk_en;
    logic       reset_n;
    logic       leds_en;
    logic       osc_zero;
    logic       osc_valid;
    logic       mix_valid;
    logic [7:0] leds;
  } rb_status_t;

endpackage

// ==== rtl/rb_sys_regs.sv ====
// RadioBox register bank on the strobe/ack system bus, with registered read mux and status capture
module rb_sys_regs import rb_pkg::*; (
  input  logic         clk_adc_125mhz,
  input  logic         adc_rstn_i,
  input  rb_sys_req_t  sys_req,
  output rb_sys_rsp_t  sys_rsp,
  input  rb_status_t   status,
  output logic         rb_enable,
  output rb_led_mode_e led_mode,
  output rb_osc_cfg_t  osc_cfg,
  output rb_mix_cfg_t  mix_cfg
);

  rb_word_t    ctrl_q;
  rb_word_t    led_ctrl_q;
  rb_word_t    inc_lo_q;
  logic [15:0] inc_hi_q;     // upper 16 bits read as zero
  rb_word_t    ofs_lo_q;
  logic [15:0] ofs_hi_q;
  rb_word_t    gain_q;
  rb_word_t    mofs_lo_q;
  logic [15:0] mofs_hi_q;
  rb_word_t    stat_w;
  rb_word_t    stat_q;
  rb_word_t    rdata_q;
  logic        ack_q;

  wire [19:0] addr = sys_req.address[19:0];  // only low 20 bits decoded

  // ----------------------------------------------------------
  // write decode
  // ----------------------------------------------------------
  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      ctrl_q     <= '0;
      led_ctrl_q <= '0;
      inc_lo_q   <= '0;
      inc_hi_q   <= '0;
      ofs_lo_q   <= '0;
      ofs_hi_q   <= '0;
      gain_q     <= '0;
      mofs_lo_q  <= '0;
      mofs_hi_q  <= '0;
    end else if (sys_req.wen) begin
      case (addr)
        RB_ADDR_CTRL:       ctrl_q     <= sys_req.wdata;
        RB_ADDR_LED_CTRL:   led_ctrl_q <= sys_req.wdata;
        RB_ADDR_OSC_INC_LO: inc_lo_q   <= sys_req.wdata;
        RB_ADDR_OSC_INC_HI: inc_hi_q   <= sys_req.wdata[15:0];  // masked
        RB_ADDR_OSC_OFS_LO: ofs_lo_q   <= sys_req.wdata;
        RB_ADDR_OSC_OFS_HI: ofs_hi_q   <= sys_req.wdata[15:0];
        RB_ADDR_MIX_GAIN:   gain_q     <= sys_req.wdata;
        RB_ADDR_MIX_OFS_LO: mofs_lo_q  <= sys_req.wdata;
        RB_ADDR_MIX_OFS_HI: mofs_hi_q  <= sys_req.wdata[15:0];
        default: ;                                  // unmapped, dropped
      endcase
    end
  end

  // ----------------------------------------------------------
  // status capture, every cycle
  // ----------------------------------------------------------
  always_comb begin
    stat_w                            = '0;
    stat_w[RB_STAT_CLK_EN]            = status.clk_en;
    stat_w[RB_STAT_RESET]             = status.reset_n;
    stat_w[RB_STAT_LEDS_EN]           = status.leds_en;
    stat_w[RB_STAT_OSC_ZERO]          = status.osc_zero;
    stat_w[RB_STAT_OSC_VALID]         = status.osc_valid;
    stat_w[RB_STAT_MIX_VALID]         = status.mix_valid;
    stat_w[RB_STAT_LED_LSB +: 8]      = status.leds;   // led mirror
  end

  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) stat_q <= '0;
    else             stat_q <= stat_w;
  end

  // read mux, result valid with ack
  always_ff @(posedge clk_adc_125mhz) begin
    if (sys_req.ren) begin
      case (addr)
        RB_ADDR_CTRL:       rdata_q <= ctrl_q;
        RB_ADDR_STATUS:     rdata_q <= stat_q;
        RB_ADDR_LED_CTRL:   rdata_q <= led_ctrl_q;
        RB_ADDR_OSC_INC_LO: rdata_q <= inc_lo_q;
        RB_ADDR_OSC_INC_HI: rdata_q <= {16'h0, inc_hi_q};
        RB_ADDR_OSC_OFS_LO: rdata_q <= ofs_lo_q;
        RB_ADDR_OSC_OFS_HI: rdata_q <= {16'h0, ofs_hi_q};
        RB_ADDR_MIX_GAIN:   rdata_q <= gain_q;
        RB_ADDR_MIX_OFS_LO: rdata_q <= mofs_lo_q;
        RB_ADDR_MIX_OFS_HI: rdata_q <= {16'h0, mofs_hi_q};
        default:            rdata_q <= '0;     // unmapped reads zero
      endcase
    end
  end

  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) ack_q <= 1'b0;
    else             ack_q <= sys_req.wen | sys_req.ren;  // every access acked
  end

  assign sys_rsp   = '{rdata: rdata_q, err: 1'b0, ack: ack_q};
  assign rb_enable = ctrl_q[RB_CTRL_ENABLE];
  assign led_mode  = rb_led_mode_e'(led_ctrl_q[3:0]);
  assign osc_cfg   = '{inc: {inc_hi_q, inc_lo_q}, ofs: {ofs_hi_q, ofs_lo_q},
                       resync: ctrl_q[RB_CTRL_OSC_RESYNC]};
  assign mix_cfg   = '{gain: gain_q, ofs: {mofs_hi_q, mofs_lo_q}};

  // master waits for ack before the next strobe, so ack is always a lone pulse
  a_ack_pulse: assert property (@(posedge clk_adc_125mhz) disable iff (!adc_rstn_i)
    ack_q |=> !ack_q);

endmodule

// ==== rtl/rb_enable_seq.sv ====
// RadioBox enable sequencer: clock enable up before reset release, reset before clock stop
module rb_enable_seq import rb_pkg::*; (
  input  logic clk_adc_125mhz,
  input  logic adc_rstn_i,
  input  logic rb_enable,
  output logic rb_clk_en,
  output logic rb_reset_n
);

  logic       en_last;   // enable bit, one cycle late
  logic [1:0] seq_ctr;   // settle timer

  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i) begin
      en_last    <= 1'b0;
      rb_clk_en  <= 1'b0;
      rb_reset_n <= 1'b0;
      seq_ctr    <= '0;
    end else begin
      en_last <= rb_enable;
      if (rb_enable != en_last) begin
        seq_ctr <= 2'd3;                 // reload on any edge
        if (rb_enable)
          rb_clk_en  <= 1'b1;            // power up, clock first
        else
          rb_reset_n <= 1'b0;            // sleep, reset first
      end else if (seq_ctr != 2'd0) begin
        seq_ctr <= seq_ctr - 2'd1;
      end else if (rb_enable) begin
        rb_reset_n <= 1'b1;              // timer elapsed, release
      end else begin
        rb_clk_en  <= 1'b0;              // timer elapsed, stop clock
      end
    end
  end

  // processing blocks only leave reset with a running clock enable
  a_rst_needs_clk: assert property (@(posedge clk_adc_125mhz) disable iff (!adc_rstn_i)
    rb_reset_n |-> rb_clk_en);

endmodule

// ==== rtl/rb_dds_osc.sv ====
// RadioBox DDS oscillator: phase accumulator with offset and resync, sawtooth sample out
module rb_dds_osc import rb_pkg::*; #(
  parameter int PHASE_W = 48
) (
  input  logic        clk_adc_125mhz,
  input  logic        rb_clk_en,
  input  logic        rb_reset_n,
  input  rb_osc_cfg_t osc_cfg,
  output rb_sample_t  osc_sample,
  output logic        osc_valid
);

  logic [PHASE_W-1:0] phase_q;
  logic [PHASE_W-1:0] phase_ofs;  // phase seen at the output

  assign phase_ofs = phase_q + osc_cfg.ofs[PHASE_W-1:0];

  // ----------------------------------------------------------
  // accumulator and sample register
  // ----------------------------------------------------------
  always_ff @(posedge clk_adc_125mhz) begin
    if (!rb_reset_n) begin
      phase_q   <= '0;
      osc_valid <= 1'b0;
    end else if (rb_clk_en) begin
      osc_valid <= 1'b1;                        // first enabled cycle on
      if (osc_cfg.resync)
        phase_q <= '0;                          // held at zero
      else
        phase_q <= phase_q + osc_cfg.inc[PHASE_W-1:0];  // wraps mod 2^PHASE_W
    end
  end

  // sample is the top 16 bits of the offset phase
  always_ff @(posedge clk_adc_125mhz) begin
    if (rb_clk_en)
      osc_sample <= phase_ofs[PHASE_W-1 -: 16];
  end

endmodule

// ==== rtl/rb_mix_multadd.sv ====
// RadioBox mixer that multiplies by a signed gain and adds an unsigned offset over MIX_LAT stages
module rb_mix_multadd import rb_pkg::*; #(
  parameter int MIX_LAT = 4   // at least 2 for mult and add
) (
  input  logic        clk_adc_125mhz,
  input  logic        rb_clk_en,
  input  logic        rb_reset_n,
  input  rb_sample_t  osc_sample,
  input  logic        osc_valid,
  input  rb_mix_cfg_t mix_cfg,
  output rb_sample_t  mix_sample,
  output logic        mix_valid
);

  typedef struct packed {
    logic      vld;
    rb_phase_t data;
  } mix_stage_t;

  mix_stage_t         stg [MIX_LAT];  // pipeline stages carrying data with its valid
  logic signed [47:0] prod;           // 16 x 32 signed fits in 48

  assign prod = osc_sample * $signed(mix_cfg.gain);

  // ----------------------------------------------------------
  // pipeline advancing only on clock enable
  // ----------------------------------------------------------
  always_ff @(posedge clk_adc_125mhz) begin
    if (!rb_reset_n) begin
      for (int i = 0; i < MIX_LAT; i++)
        stg[i].vld <= 1'b0;                     // data left as is
    end else if (rb_clk_en) begin
      stg[0] <= '{vld: osc_valid, data: {prod[46:0], 1'b0}};  // gain x2
      stg[1] <= '{vld: stg[0].vld, data: stg[0].data + mix_cfg.ofs};  // mod 2^48
      for (int i = 2; i < MIX_LAT; i++)
        stg[i] <= stg[i-1];                     // delay only
    end
  end

  assign mix_sample = stg[MIX_LAT-1].data[47:32];
  assign mix_valid  = stg[MIX_LAT-1].vld;

  // output valid appears only while the clock enable runs
  a_vld_on_clk_en: assert property (@(posedge clk_adc_125mhz) disable iff (!rb_reset_n)
    $rose(mix_valid) |-> rb_clk_en);

endmodule

// ==== rtl/rb_led_magnitude.sv ====
// RadioBox LED magnitude indicator: bar pattern from a selected sample at a divided rate
module rb_led_magnitude import rb_pkg::*; #(
  parameter int LED_DIV_W = 20   // update period 2^LED_DIV_W cycles
) (
  input  logic         clk_adc_125mhz,
  input  logic         adc_rstn_i,
  input  logic         rb_reset_n,
  input  logic         rb_en,
  input  rb_led_mode_e led_mode,
  input  rb_sample_t   osc_sample,
  input  rb_sample_t   mix_sample,
  output logic         leds_en,
  output logic [7:0]   leds
);

  logic [LED_DIV_W-1:0] div_ctr;

  // ----------------------------------------------------------
  // sample to bar, positive grows left, negative grows right
  // ----------------------------------------------------------
  function automatic logic [7:0] mag_bar(input rb_sample_t val);
    logic [7:0] bar;
    bar = 8'h00;                          // exact zero
    if (!val[15]) begin
      if (val[14])         bar = 8'hF0;
      else if (val[13])    bar = 8'h70;
      else if (val[12])    bar = 8'h30;
      else if (val[11])    bar = 8'h10;
      else if (val != '0)  bar = 8'h80;   // small positive
    end else begin
      if (!val[14])        bar = 8'h0F;
      else if (!val[13])   bar = 8'h0E;
      else if (!val[12])   bar = 8'h0C;
      else if (!val[11])   bar = 8'h08;
      else                 bar = 8'h01;   // small negative
    end
    return bar;
  endfunction

  always_ff @(posedge clk_adc_125mhz) begin
    if (!adc_rstn_i || !rb_reset_n) begin
      leds_en <= 1'b0;
      leds    <= 8'h00;
      div_ctr <= '0;
    end else if (led_mode != DISABLED && rb_en) begin
      leds_en <= 1'b1;                    // indicator owns the leds
      div_ctr <= div_ctr + 1'b1;
      if (div_ctr == '0) begin            // divided update
        case (led_mode)
          OSC_MAG: leds <= mag_bar(osc_sample);
          MIX_MAG: leds <= mag_bar(mix_sample);
          default: leds <= 8'h00;         // off and unknown modes
        endcase
      end
    end else begin
      leds_en <= 1'b0;
      leds    <= 8'h00;
      div_ctr <= '0;
    end
  end

endmodule

// ==== rtl/rb_radiobox_top.sv ====
// RadioBox single channel signal source: register bank, sequencer, DDS, mixer and LED indicator
module rb_radiobox_top import rb_pkg::*; #(
  parameter int PHASE_W   = 48,
  parameter int MIX_LAT   = 4,
  parameter int LED_DIV_W = 20
) (
  input  logic        clk_adc_125mhz,
  input  logic        adc_rstn_i,
  input  rb_sys_req_t sys_req,
  output rb_sys_rsp_t sys_rsp,
  output logic        rb_en,          // output sample valid
  output rb_sample_t  rb_out,
  output logic        rb_leds_en,
  output logic [7:0]  rb_leds_data
);

  logic         rb_enable;
  logic         rb_clk_en;
  logic         rb_reset_n;
  rb_led_mode_e led_mode;
  rb_osc_cfg_t  osc_cfg;
  rb_mix_cfg_t  mix_cfg;
  rb_sample_t   osc_sample;
  logic         osc_valid;
  logic         mix_valid;
  rb_status_t   status;

  // ----------------------------------------------------------
  // input side
  // ----------------------------------------------------------
  rb_sys_regs u_rb_sys_regs (
    .clk_adc_125mhz (clk_adc_125mhz),
    .adc_rstn_i     (adc_rstn_i),
    .sys_req        (sys_req),
    .sys_rsp        (sys_rsp),
    .status         (status),
    .rb_enable      (rb_enable),
    .led_mode       (led_mode),
    .osc_cfg        (osc_cfg),
    .mix_cfg        (mix_cfg)
  );

  // ----------------------------------------------------------
  // processing
  // ----------------------------------------------------------
  rb_enable_seq u_rb_enable_seq (
    .clk_adc_125mhz (clk_adc_125mhz),
    .adc_rstn_i     (adc_rstn_i),
    .rb_enable      (rb_enable),
    .rb_clk_en      (rb_clk_en),
    .rb_reset_n     (rb_reset_n)
  );

  rb_dds_osc #(.PHASE_W(PHASE_W)) u_rb_dds_osc (
    .clk_adc_125mhz (clk_adc_125mhz),
    .rb_clk_en      (rb_clk_en),
    .rb_reset_n     (rb_reset_n),
    .osc_cfg        (osc_cfg),
    .osc_sample     (osc_sample),
    .osc_valid      (osc_valid)
  );

  rb_mix_multadd #(.MIX_LAT(MIX_LAT)) u_rb_mix_multadd (
    .clk_adc_125mhz (clk_adc_125mhz),
    .rb_clk_en      (rb_clk_en),
    .rb_reset_n     (rb_reset_n),
    .osc_sample     (osc_sample),
    .osc_valid      (osc_valid),
    .mix_cfg        (mix_cfg),
    .mix_sample     (rb_out),
    .mix_valid      (mix_valid)
  );

  // ----------------------------------------------------------
  // output side
  // ----------------------------------------------------------
  rb_led_magnitude #(.LED_DIV_W(LED_DIV_W)) u_rb_led_magnitude (
    .clk_adc_125mhz (clk_adc_125mhz),
    .adc_rstn_i     (adc_rstn_i),
    .rb_reset_n     (rb_reset_n),
    .rb_en          (rb_en),
    .led_mode       (led_mode),
    .osc_sample     (osc_sample),
    .mix_sample     (rb_out),
    .leds_en        (rb_leds_en),
    .leds           (rb_leds_data)
  );

  assign rb_en  = mix_valid;
  assign status = '{clk_en:    rb_clk_en,
                    reset_n:   rb_reset_n,
                    leds_en:   rb_leds_en,
                    osc_zero:  (osc_sample == '0),  // zero flag
                    osc_valid: osc_valid,
                    mix_valid: mix_valid,
                    leds:      rb_leds_data};

endmodule

// ==== test/tb_rb_radiobox.sv ====
// RadioBox testbench: runs bus, enable, sample and LED checks from the pattern file
module tb_rb_radiobox
  import rb_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int LED_DIV_W = 4;    // short led period
  localparam int MIX_LAT   = 4;
  localparam int MAX_REC   = 64;
  localparam int OP_WRITE  = 0;
  localparam int OP_READ   = 1;
  localparam int OP_WAIT   = 2;    // poll until masked value matches
  localparam int OP_SAMPLE = 3;
  localparam int OP_LED    = 4;
  localparam int OP_END    = 15;

  logic        clk_adc_125mhz;
  logic        adc_rstn_i;
  rb_sys_req_t sys_req;
  rb_sys_rsp_t sys_rsp;
  logic        rb_en;
  rb_sample_t  rb_out;
  logic        rb_leds_en;
  logic [7:0]  rb_leds_data;

  rb_word_t pat_mem [4*MAX_REC];   // four words per record
  int       n_rec       = 0;
  int       errors      = 0;
  int       tests_ok    = 0;
  int       tests_bad   = 0;
  int       cycles      = 0;
  int       cycle_limit = 1000;    // replaced once the records are counted

  rb_radiobox_top #(
    .MIX_LAT   (MIX_LAT),
    .LED_DIV_W (LED_DIV_W)
  ) u_rb_radiobox_top (
    .clk_adc_125mhz (clk_adc_125mhz),
    .adc_rstn_i     (adc_rstn_i),
    .sys_req        (sys_req),
    .sys_rsp        (sys_rsp),
    .rb_en          (rb_en),
    .rb_out         (rb_out),
    .rb_leds_en     (rb_leds_en),
    .rb_leds_data   (rb_leds_data)
  );

  // ------------------------------------------------------------
  // clock and watchdog
  // ------------------------------------------------------------
  initial begin
    clk_adc_125mhz = 1'b0;
    forever #4 clk_adc_125mhz = ~clk_adc_125mhz;  // 125 MHz
  end

  always @(posedge clk_adc_125mhz) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, the DUT stopped responding", cycles);
      $display("Testbench failed");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // compare tasks
  // ------------------------------------------------------------
  task automatic check_word(input string name, input rb_word_t got, input rb_word_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_sample(input string name, input rb_sample_t got, input rb_sample_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got 0x%04h expected 0x%04h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_leds(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got 0x%02h expected 0x%02h", name, got, exp);
      errors++;
    end
  endtask

  task automatic flag_error(input string msg);
    $display("ERROR %s", msg);
    errors++;
  endtask

  // one strobe, ack expected exactly one cycle later
  task automatic bus_access(input logic wr, input rb_word_t addr, input rb_word_t wdata,
                            output rb_word_t rdata);
    @(posedge clk_adc_125mhz);
    sys_req <= '{address: addr, wdata: wdata, wen: wr, ren: !wr};
    @(negedge clk_adc_125mhz);
    if (sys_rsp.ack) flag_error("ack arrived in the strobe cycle");
    @(posedge clk_adc_125mhz);
    sys_req <= '{address: addr, wdata: wdata, wen: 1'b0, ren: 1'b0};
    @(negedge clk_adc_125mhz);
    if (!sys_rsp.ack) flag_error("no ack one cycle after the strobe");
    if (sys_rsp.err)  flag_error("bus returned an error");
    rdata = sys_rsp.rdata;
  endtask

  task automatic wait_rb_en();
    while (!rb_en) @(negedge clk_adc_125mhz);  // watchdog bounds this
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------
  initial begin
    rb_word_t   op;
    rb_word_t   addr;
    rb_word_t   data;
    rb_word_t   expv;
    rb_word_t   rd;
    rb_sample_t prev;
    rb_sample_t diff;
    int         err_before;
    string      kind;
    sys_req    = '0;
    adc_rstn_i = 1'b0;
    $readmemh("test/rb_test_patterns.txt", pat_mem);
    while (n_rec < MAX_REC && pat_mem[4*n_rec] !== rb_word_t'(OP_END)
           && !$isunknown(pat_mem[4*n_rec]))
      n_rec++;
    if (n_rec == 0) flag_error("no records read from the pattern file");
    cycle_limit = n_rec * 64 + (1 << LED_DIV_W) * 4;
    repeat (3) @(posedge clk_adc_125mhz);
    adc_rstn_i <= 1'b1;
    @(negedge clk_adc_125mhz);
    check_word("{ack, rb_leds_en, rb_en} after reset",
               {29'b0, sys_rsp.ack, rb_leds_en, rb_en}, '0);
    check_leds("rb_leds_data after reset", rb_leds_data, 8'h00);
    for (int r = 0; r < n_rec; r++) begin
      op         = pat_mem[4*r];
      addr       = pat_mem[4*r+1];
      data       = pat_mem[4*r+2];
      expv       = pat_mem[4*r+3];
      err_before = errors;
      case (op)
        OP_WRITE: begin
          kind = "write";
          bus_access(1'b1, addr, data, rd);
        end
        OP_READ: begin
          kind = "read";
          bus_access(1'b0, addr, '0, rd);
          check_word($sformatf("rdata at 0x%08h", addr), rd, expv);
        end
        OP_WAIT: begin
          kind = "wait-valid";
          do begin
            bus_access(1'b0, addr, '0, rd);
          end while ((rd & data) != expv);
          if (expv[RB_STAT_RESET])
            wait_rb_en();                        // output follows the reset release
          else if (rb_en)
            flag_error("rb_en still high after the subsystem went to sleep");
        end
        OP_SAMPLE: begin
          kind = "sample";
          wait_rb_en();
          repeat (MIX_LAT + 4) @(negedge clk_adc_125mhz);  // let new config settle
          if (data == 0) begin
            check_sample("rb_out", rb_out, expv[15:0]);
          end else begin
            prev = rb_out;
            for (int i = 0; i < data; i++) begin
              @(negedge clk_adc_125mhz);
              if (!rb_en) flag_error("rb_en dropped during the sample run");
              diff = rb_out - prev;              // mod 2^16
              check_sample("rb_out step", diff, expv[15:0]);
              prev = rb_out;
            end
          end
        end
        OP_LED: begin
          kind = "led";
          repeat ((1 << LED_DIV_W) + MIX_LAT + 4) @(negedge clk_adc_125mhz);
          check_word("rb_leds_en", 32'(rb_leds_en), data);
          check_leds("rb_leds_data", rb_leds_data, expv[7:0]);
          bus_access(1'b0, 32'(RB_ADDR_STATUS), '0, rd);
          check_leds("status leds", rd[RB_STAT_LED_LSB +: 8], expv[7:0]);
        end
        default: begin
          kind = "unknown";
          flag_error($sformatf("unknown operation %0h in record %0d", op, r));
        end
      endcase
      if (errors == err_before) begin
        tests_ok++;
        $display("test %0d %s ok", r, kind);
      end else begin
        tests_bad++;
        $display("test %0d %s FAILED", r, kind);
      end
    end
    $display("%0d tests, %0d ok, %0d bad, %0d errors", n_rec, tests_ok, tests_bad, errors);
    if (errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

// ==== test/rb_test_patterns.txt ====
// op addr data expected, hex; op 0 write, 1 read-check, 2 wait-valid (data is the mask),
// 3 sample-check (data is a step count, 0 for a level), 4 led-check (data is leds_en), f end
0 0001c 00000003 00000000
1 0001c 00000000 00000003
1 0010001c 00000000 00000003  // upper address bits ignored
0 00020 a5a55a5a 00000000
1 00020 00000000 a5a55a5a
0 00024 deadbeef 00000000
1 00024 00000000 0000beef
0 00028 13572468 00000000
1 00028 00000000 13572468
0 0002c ffff1234 00000000
1 0002c 00000000 00001234
0 00030 40000000 00000000
1 00030 00000000 40000000
0 00038 0badf00d 00000000
1 00038 00000000 0badf00d
0 0003c 12345678 00000000
1 0003c 00000000 00005678
1 00040 00000000 00000000     // unmapped
0 00020 00000000 00000000
0 00024 00000000 00000000
0 00028 00000000 00000000
0 00038 00000000 00000000
0 0003c 00000000 00000000
0 00000 00000001 00000000
1 00000 00000000 00000001
2 00004 00000003 00000003     // clk_en and reset released
3 00000 00000000 0000091a     // 1234 halved
4 00000 00000001 00000030     // osc 1234
0 0001c 00000002 00000000
4 00000 00000001 00000010     // mix 091a
0 0001c 00000001 00000000
4 00000 00000001 00000000
0 0001c 00000000 00000000
4 00000 00000000 00000000
0 0002c 00008001 00000000
3 00000 00000000 0000c000     // floor of -32767/2
0 0001c 00000003 00000000
4 00000 00000001 0000000f
0 00030 00000000 00000000
0 0003c 00005a5a 00000000
3 00000 00000000 00005a5a     // offset only
0 0003c 00000000 00000000
0 00030 40000000 00000000
0 00024 00000002 00000000
3 00000 00000014 00000001     // ramp, step 1
0 00000 00000000 00000000
2 00004 00000003 00000000
f 00000 00000000 00000000

// ==== build.f ====
rtl/rb_pkg.sv
rtl/rb_sys_regs.sv
rtl/rb_enable_seq.sv
rtl/rb_dds_osc.sv
rtl/rb_mix_multadd.sv
rtl/rb_led_magnitude.sv
rtl/rb_radiobox_top.sv
test/tb_rb_radiobox.sv
